// ==== rtl/alu_pkg.sv ====
// alu constant set: command codes, operand and carry sources, flag ops, psw layout
package alu_pkg;

  // ==================================================
  // datapath
  // ==================================================
  localparam int data_w = 8;                      // one byte per word

  // ==================================================
  // alu_cmd codes
  // ==================================================
  localparam logic [3:0] alu_add  = 4'h0;         // adder result
  localparam logic [3:0] alu_and  = 4'h1;         // bitwise and
  localparam logic [3:0] alu_or   = 4'h2;         // bitwise or
  localparam logic [3:0] alu_xor  = 4'h3;         // bitwise xor
  localparam logic [3:0] alu_not  = 4'h4;         // invert a
  localparam logic [3:0] alu_shl  = 4'h5;         // shift left, zero fill
  localparam logic [3:0] alu_shr  = 4'h6;         // shift right, zero fill
  localparam logic [3:0] alu_asr  = 4'h7;         // shift right, sign fill
  localparam logic [3:0] alu_tha  = 4'h8;         // pass a
  localparam logic [3:0] alu_thb  = 4'h9;         // pass b
  localparam logic [3:0] alu_ror  = 4'ha;         // rotate right
  localparam logic [3:0] alu_rorc = 4'hb;         // rotate right through carry
  // codes 12..15 give a zero result

  // ==================================================
  // operand sources
  // ==================================================
  // a side decodes bit 0 only
  localparam logic [1:0] asrc_imm  = 2'b01;       // immediate from queue
  // b side, 0 and 3 both pick register data
  localparam logic [1:0] bsrc_zero = 2'b01;       // constant zero
  localparam logic [1:0] bsrc_sign = 2'b10;       // saved a sign, replicated

  // ==================================================
  // carry-in sources
  // ==================================================
  localparam logic [2:0] cry_zero  = 3'd0;        // carry in 0
  localparam logic [2:0] cry_one   = 3'd1;        // carry in 1, used for subtract
  localparam logic [2:0] cry_not_c = 3'd2;        // inverted c flag
  localparam logic [2:0] cry_saved = 3'd3;        // adder carry of last cycle
  localparam logic [2:0] cry_c     = 3'd4;        // c flag, also codes 5..7

  // ==================================================
  // flag_op codes
  // ==================================================
  // low two bits pick which of z/c/n/v get updated
  localparam logic [2:0] fl_nul  = 3'b000;        // keep all flags
  localparam logic [2:0] fl_zn   = 3'b001;        // z and n
  localparam logic [2:0] fl_zcn  = 3'b010;        // z, c and n
  localparam logic [2:0] fl_zcnv = 3'b011;        // z, c, n and v
  localparam logic [2:0] fl_clie = 3'b100;        // clear interrupt enable
  localparam logic [2:0] fl_wzcn = 3'b110;        // word zero, c and n

  // ==================================================
  // psw bit positions
  // ==================================================
  localparam int psw_z  = 0;                      // zero
  localparam int psw_c  = 1;                      // carry
  localparam int psw_n  = 2;                      // negative
  localparam int psw_v  = 3;                      // overflow
  localparam int psw_ie = 4;                      // interrupt enable
  // bits 7..5 are carried through untouched

endpackage

// ==== rtl/alu_operand_if.sv ====
`timescale 1ns/1ps
// alu operand bundle carrying prepared operands from the selector to the units
interface alu_operand_if
  import alu_pkg::*;
();

  logic [data_w-1:0] a_op;      // selected a operand
  logic [data_w-1:0] b_op;      // b operand after optional inversion
  logic [data_w-1:0] b_raw;     // b operand before inversion, for overflow
  logic              carry_in;  // adder carry in
  logic [3:0]        cmd;       // alu command, passed through

  // selector drives everything
  modport src (output a_op, b_op, b_raw, carry_in, cmd);

  // adder only needs the arithmetic operands
  modport add_side (input a_op, b_op, carry_in);

  // logic unit and result stage
  modport res_side (input a_op, b_op, b_raw, cmd);

endinterface

// ==== rtl/operand_select.sv ====
`timescale 1ns/1ps
// alu operand selector: a/b muxes, b inversion, carry-in choice, saved carry and sign
module operand_select
  import alu_pkg::*;
(
  input  logic              clk,          // clock
  input  logic              rst_n,        // async reset, active low
  input  logic [1:0]        a_src,        // a operand source
  input  logic [1:0]        b_src,        // b operand source
  input  logic [2:0]        carry_src,    // carry-in source
  input  logic [3:0]        alu_cmd,      // alu command
  input  logic              invert_b,     // invert b for subtract
  input  logic [data_w-1:0] queue_out,    // immediate from queue
  input  logic [data_w-1:0] a_data,       // register bank a port
  input  logic [data_w-1:0] b_data,       // register bank b port
  input  logic              c_flag,       // current psw carry
  input  logic              adder_carry,  // carry out of the adder, this cycle
  alu_operand_if.src        ops           // prepared operands
);

  logic saved_carry;  // adder carry of the previous cycle
  logic saved_sign;   // a operand msb of the previous cycle
  logic sel_imm;      // a side picks the immediate

  // ==================================================
  // a operand
  // ==================================================
  assign sel_imm = (a_src[0] == asrc_imm[0]);  // only bit 0 is decoded

  always_comb
  begin
    if (sel_imm)
      ops.a_op = queue_out;                   // immediate operand
    else
      ops.a_op = a_data;                      // register operand
  end

  // ==================================================
  // b operand
  // ==================================================
  always_comb
  begin
    case (b_src)
      bsrc_zero: ops.b_raw = '0;                       // inc/dec, carry only
      bsrc_sign: ops.b_raw = {data_w{saved_sign}};     // upper byte of sign extension
      default:   ops.b_raw = b_data;                   // codes 0 and 3
    endcase
  end

  assign ops.b_op = invert_b ? ~ops.b_raw : ops.b_raw; // one's complement for subtract

  // ==================================================
  // carry in
  // ==================================================
  always_comb
  begin
    case (carry_src)
      cry_zero:  ops.carry_in = 1'b0;
      cry_one:   ops.carry_in = 1'b1;         // completes two's complement
      cry_not_c: ops.carry_in = ~c_flag;      // borrow style
      cry_saved: ops.carry_in = saved_carry;  // high byte of a 16-bit op
      cry_c:     ops.carry_in = c_flag;
      default:   ops.carry_in = c_flag;       // 5..7 alias cry_c
    endcase
  end

  assign ops.cmd = alu_cmd;                   // straight through to the units

  // ==================================================
  // saved state for chained word operations
  // ==================================================
  // captured every cycle whatever the command
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      saved_carry <= 1'b0;
      saved_sign  <= 1'b0;
    end
    else
    begin
      saved_carry <= adder_carry;             // low byte carry for next cycle
      saved_sign  <= ops.a_op[data_w-1];      // sign of low byte operand
    end
  end

endmodule

// ==== rtl/cla_adder.sv ====
`timescale 1ns/1ps
// alu adder: carry-lookahead in 4-bit groups, group carry rippled upward
module cla_adder
  import alu_pkg::*;
(
  alu_operand_if.add_side    ops,        // a, inverted-or-not b, carry in
  output logic [data_w-1:0]  sum,        // sum bits
  output logic               carry_out   // carry out of the msb
);

  logic [data_w-1:0] gen;    // per-bit generate
  logic [data_w-1:0] prop;   // per-bit propagate
  logic [data_w:0]   cry;    // carry into each bit, cry[data_w] is the output

  // four carries of one group from its g/p terms and its carry in
  function automatic logic [3:0] lookahead4(
    input logic [3:0] g,
    input logic [3:0] p,
    input logic       ci
  );
    logic [3:0] c;
    c[0] = g[0] | (p[0] & ci);
    c[1] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & ci);
    c[2] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
         | (p[2] & p[1] & p[0] & ci);
    c[3] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
         | (p[3] & p[2] & p[1] & g[0])
         | (p[3] & p[2] & p[1] & p[0] & ci);
    return c;
  endfunction

  // ==================================================
  // bit terms
  // ==================================================
  assign gen    = ops.a_op & ops.b_op;    // both ones
  assign prop   = ops.a_op ^ ops.b_op;    // exactly one
  assign cry[0] = ops.carry_in;

  // ==================================================
  // lookahead groups
  // ==================================================
  // upper group takes the lower group's carry out
  for (genvar j = 0; j < data_w / 4; j++)
  begin : g_grp
    assign cry[4*j+1 +: 4] = lookahead4(gen[4*j +: 4], prop[4*j +: 4], cry[4*j]);
  end

  assign sum       = prop ^ cry[data_w-1:0];  // half-sum with incoming carry
  assign carry_out = cry[data_w];

endmodule

// ==== rtl/logic_unit.sv ====
`timescale 1ns/1ps
// alu logic unit: bitwise, shift, rotate and pass operations on prepared operands
module logic_unit
  import alu_pkg::*;
(
  alu_operand_if.res_side    ops,      // prepared operands and command
  input  logic               c_flag,   // psw carry, for rotate through carry
  output logic [data_w-1:0]  lu_out    // logic result
);

  logic [data_w-1:0] a;  // short names for the case below
  logic [data_w-1:0] b;

  assign a = ops.a_op;
  assign b = ops.b_op;   // already inverted when invert_b was set

  // ==================================================
  // operation decode
  // ==================================================
  always_comb
  begin
    case (ops.cmd)
      alu_and:  lu_out = a & b;
      alu_or:   lu_out = a | b;
      alu_xor:  lu_out = a ^ b;
      alu_not:  lu_out = ~a;
      alu_shl:  lu_out = {a[data_w-2:0], 1'b0};          // msb goes to carry
      alu_shr:  lu_out = {1'b0, a[data_w-1:1]};          // lsb goes to carry
      alu_asr:  lu_out = {a[data_w-1], a[data_w-1:1]};   // keep sign
      alu_tha:  lu_out = a;
      alu_thb:  lu_out = b;
      alu_ror:  lu_out = {a[0], a[data_w-1:1]};          // lsb wraps to msb
      alu_rorc: lu_out = {c_flag, a[data_w-1:1]};        // old carry into msb
      default:  lu_out = '0;                             // add and unused codes
    endcase
  end

endmodule

// ==== rtl/result_flags.sv ====
`timescale 1ns/1ps
// alu result stage: picks the result, builds next flags, registers both outputs
module result_flags
  import alu_pkg::*;
(
  input  logic              clk,        // clock
  input  logic              rst_n,      // async reset, active low
  alu_operand_if.res_side   ops,        // operands and command
  input  logic [data_w-1:0] sum,        // adder result
  input  logic              carry_out,  // adder carry
  input  logic [data_w-1:0] lu_out,     // logic unit result
  input  logic [2:0]        flag_op,    // flag update select
  input  logic [7:0]        psw,        // current flag word
  output logic [data_w-1:0] alu_out,    // registered result
  output logic [7:0]        next_psw    // registered next flag word
);

  logic [data_w-1:0] result;   // unregistered result
  logic              z_nxt;    // zero, word-chained when asked
  logic              c_nxt;
  logic              n_nxt;
  logic              v_nxt;
  logic              word_op;  // second byte of a 16-bit op
  logic [7:0]        psw_nxt;  // merged flag word before the register

  // ==================================================
  // result and raw flags
  // ==================================================
  assign result  = (ops.cmd == alu_add) ? sum : lu_out;
  assign word_op = (flag_op == fl_wzcn);

  // zero over both bytes needs the low byte's z
  assign z_nxt = (result == '0) & (word_op ? psw[psw_z] : 1'b1);
  assign n_nxt = result[data_w-1];

  always_comb
  begin
    if (ops.cmd == alu_add)
      c_nxt = carry_out;
    else if (ops.cmd == alu_shl)
      c_nxt = ops.a_op[data_w-1];   // bit shifted out on the left
    else
      c_nxt = ops.a_op[0];          // right shifts and rotates
  end

  // same-sign operands giving a different-sign result
  assign v_nxt = (ops.a_op[data_w-1] == ops.b_raw[data_w-1])
               & (result[data_w-1] != ops.a_op[data_w-1]);

  // ==================================================
  // flag merge
  // ==================================================
  always_comb
  begin
    psw_nxt = psw;                                   // bits 7..5 ride through
    if (flag_op == fl_clie)
      psw_nxt[psw_ie] = 1'b0;                        // interrupts off
    case (flag_op[1:0])
      fl_zn[1:0]:
      begin
        psw_nxt[psw_z] = z_nxt;
        psw_nxt[psw_n] = n_nxt;
      end
      fl_zcn[1:0]:                                   // also fl_wzcn
      begin
        psw_nxt[psw_z] = z_nxt;
        psw_nxt[psw_c] = c_nxt;
        psw_nxt[psw_n] = n_nxt;
      end
      fl_zcnv[1:0]:
      begin
        psw_nxt[psw_z] = z_nxt;
        psw_nxt[psw_c] = c_nxt;
        psw_nxt[psw_n] = n_nxt;
        psw_nxt[psw_v] = v_nxt;
      end
      default: ;                                     // fl_nul, fl_clie leave z/c/n/v
    endcase
  end

  // ==================================================
  // output register
  // ==================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      alu_out  <= '0;
      next_psw <= '0;
    end
    else
    begin
      alu_out  <= result;
      next_psw <= psw_nxt;
    end
  end

endmodule

// ==== rtl/risc8_alu.sv ====
`timescale 1ns/1ps
// risc8 alu top: operand select, adder and logic unit side by side, result register
module risc8_alu
  import alu_pkg::*;
(
  input  logic              clk,        // clock
  input  logic              rst_n,      // async reset, active low
  input  logic [1:0]        a_src,      // a operand source
  input  logic [1:0]        b_src,      // b operand source
  input  logic [2:0]        carry_src,  // carry-in source
  input  logic [3:0]        alu_cmd,    // alu command
  input  logic              invert_b,   // invert b operand
  input  logic [2:0]        flag_op,    // flag update select
  input  logic [data_w-1:0] queue_out,  // immediate data
  input  logic [data_w-1:0] a_data,     // register bank a data
  input  logic [data_w-1:0] b_data,     // register bank b data
  input  logic [7:0]        psw,        // current psw
  output logic [data_w-1:0] alu_out,    // result, one cycle later
  output logic [7:0]        next_psw    // next psw, one cycle later
);

  logic [data_w-1:0] sum;        // adder result
  logic              carry_out;  // adder carry, also saved for word ops
  logic [data_w-1:0] lu_out;     // logic unit result

  alu_operand_if ops_if ();      // prepared operand bundle

  operand_select u_sel (
    .clk         (clk),
    .rst_n       (rst_n),
    .a_src       (a_src),
    .b_src       (b_src),
    .carry_src   (carry_src),
    .alu_cmd     (alu_cmd),
    .invert_b    (invert_b),
    .queue_out   (queue_out),
    .a_data      (a_data),
    .b_data      (b_data),
    .c_flag      (psw[psw_c]),
    .adder_carry (carry_out),
    .ops         (ops_if.src)
  );

  cla_adder u_add (
    .ops       (ops_if.add_side),
    .sum       (sum),
    .carry_out (carry_out)
  );

  logic_unit u_lu (
    .ops    (ops_if.res_side),
    .c_flag (psw[psw_c]),         // rotate through carry
    .lu_out (lu_out)
  );

  result_flags u_res (
    .clk       (clk),
    .rst_n     (rst_n),
    .ops       (ops_if.res_side),
    .sum       (sum),
    .carry_out (carry_out),
    .lu_out    (lu_out),
    .flag_op   (flag_op),
    .psw       (psw),
    .alu_out   (alu_out),
    .next_psw  (next_psw)
  );

endmodule

// ==== tb/alu_checker.sv ====
`timescale 1ns/1ps
// alu checker: reference model of the alu, outputs compared one cycle after sampling
module alu_checker
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  int         phase,        // test phase, names the error lines
  input  logic [1:0] a_src,
  input  logic [1:0] b_src,
  input  logic [2:0] carry_src,
  input  logic [3:0] alu_cmd,
  input  logic       invert_b,
  input  logic [2:0] flag_op,
  input  logic [7:0] queue_out,
  input  logic [7:0] a_data,
  input  logic [7:0] b_data,
  input  logic [7:0] psw,
  input  logic [7:0] alu_out,
  input  logic [7:0] next_psw,
  output int         err_count,
  output int         check_count
);

  logic [7:0] exp_out = '0;        // expected registered result
  logic [7:0] exp_psw = '0;
  logic       m_carry = 1'b0;      // model saved adder carry
  logic       m_sign  = 1'b0;      // model saved a sign
  int         exp_phase = 0;
  int         errs = 0;
  int         checks = 0;
  string      names [5] = '{"reset", "add_family", "word_chain", "logic_unit", "random_mix"};

  assign err_count   = errs;
  assign check_count = checks;

  // ==================================================
  // reference model, one operation per edge
  // ==================================================
  task automatic model_step();
    logic [7:0] a;
    logic [7:0] b_sel;             // b before inversion
    logic [7:0] b;
    logic       cin;
    logic [8:0] wide;              // 9-bit sum, msb is carry
    logic [7:0] res;
    logic       c;
    logic [7:0] p;
    a = a_src[0] ? queue_out : a_data;
    case (b_src)
      bsrc_zero: b_sel = 8'h00;
      bsrc_sign: b_sel = {8{m_sign}};
      default:   b_sel = b_data;
    endcase
    b = invert_b ? ~b_sel : b_sel;
    case (carry_src)
      cry_zero:  cin = 1'b0;
      cry_one:   cin = 1'b1;
      cry_not_c: cin = ~psw[psw_c];
      cry_saved: cin = m_carry;
      default:   cin = psw[psw_c];
    endcase
    wide = {1'b0, a} + {1'b0, b} + {8'h00, cin};
    case (alu_cmd)
      alu_add:  res = wide[7:0];
      alu_and:  res = a & b;
      alu_or:   res = a | b;
      alu_xor:  res = a ^ b;
      alu_not:  res = ~a;
      alu_shl:  res = a << 1;
      alu_shr:  res = a >> 1;
      alu_asr:  res = $signed(a) >>> 1;
      alu_tha:  res = a;
      alu_thb:  res = b;
      alu_ror:  res = {a[0], a[7:1]};
      alu_rorc: res = {psw[psw_c], a[7:1]};      // carry flag enters at the top
      default:  res = 8'h00;
    endcase
    if (alu_cmd == alu_add)
      c = wide[8];
    else if (alu_cmd == alu_shl)
      c = a[7];
    else
      c = a[0];
    p = psw;
    if (flag_op == fl_clie)
      p[psw_ie] = 1'b0;
    if (flag_op[1:0] != 2'b00)
    begin
      p[psw_z] = (res == 8'h00) && (flag_op != fl_wzcn || psw[psw_z]);
      p[psw_n] = res[7];
    end
    if (flag_op[1])
      p[psw_c] = c;
    if (flag_op[1:0] == 2'b11)
      p[psw_v] = (a[7] == b_sel[7]) && (res[7] != a[7]);   // signed overflow
    exp_out   = res;
    exp_psw   = p;
    m_carry   = wide[8];
    m_sign    = a[7];
    exp_phase = phase;
  endtask

  task automatic report_mismatch(input string what, input logic [7:0] exp_v,
                                 input logic [7:0] act_v);
    errs = errs + 1;
    $display("[FAIL] %s %s: expected %h, actual %h", names[exp_phase], what, exp_v, act_v);
  endtask

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      exp_out   = '0;              // outputs held clear in reset
      exp_psw   = '0;
      m_carry   = 1'b0;
      m_sign    = 1'b0;
      exp_phase = 0;
    end
    else
      model_step();
  end

  // ==================================================
  // compare mid-cycle, outputs settled
  // ==================================================
  always @(negedge clk)
  begin
    checks = checks + 2;
    if (alu_out !== exp_out)
      report_mismatch("alu_out", exp_out, alu_out);
    if (next_psw !== exp_psw)
      report_mismatch("next_psw", exp_psw, next_psw);
  end

endmodule

// ==== tb/alu_assert.sv ====
`timescale 1ns/1ps
// alu result stage assertions: reset clearing, psw pass-through bits, held flags
module alu_assert
  import alu_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic [2:0] flag_op,
  input logic [7:0] psw,
  input logic [7:0] alu_out,
  input logic [7:0] next_psw
);

  int fail_count = 0;   // failures so far

  // an edge taken in reset leaves both registers clear
  reset_clear: assert property (@(posedge clk) !rst_n |=> (alu_out == '0 && next_psw == '0))
    else
    begin
      fail_count++;
      $error("outputs not cleared by reset");
    end

  upper_bits: assert property (@(posedge clk) rst_n |=> (next_psw[7:5] == $past(psw[7:5])))
    else
    begin
      fail_count++;
      $error("next_psw bits 7 to 5 differ from previous psw");
    end

  // no flag update, ie untouched too
  nul_hold: assert property (@(posedge clk)
                             (rst_n && flag_op == fl_nul) |=> (next_psw[4:0] == $past(psw[4:0])))
    else
    begin
      fail_count++;
      $error("flags changed under fl_nul");
    end

endmodule

bind result_flags alu_assert u_asrt (.*);

// ==== tb/tb_risc8_alu.sv ====
`timescale 1ns/1ps
// alu testbench driving seeded random operations in four phases, with timeout and verdict
module tb_risc8_alu
  import alu_pkg::*;
();

  localparam int reset_cycles  = 10;
  localparam int ops_per_phase = 500;
  localparam int n_phases      = 4;
  localparam int slack_cycles  = 190;   // drain plus margin
  localparam int cycle_limit   = reset_cycles + n_phases * ops_per_phase + slack_cycles;

  logic       clk = 1'b0;
  logic       rst_n;
  logic [1:0] a_src;
  logic [1:0] b_src;
  logic [2:0] carry_src;
  logic [3:0] alu_cmd;
  logic       invert_b;
  logic [2:0] flag_op;
  logic [7:0] queue_out;
  logic [7:0] a_data;
  logic [7:0] b_data;
  logic [7:0] psw;
  logic [7:0] alu_out;
  logic [7:0] next_psw;
  int         phase = 0;                // 0 idle, 1..4 test phases
  int         cycles = 0;               // clock edges since start
  int         err_count;
  int         check_count;
  logic [7:0] corner [4]   = '{8'h00, 8'h7f, 8'h80, 8'hff};   // sign and carry edges
  logic [2:0] fl_codes [6] = '{fl_nul, fl_zn, fl_zcn, fl_zcnv, fl_clie, fl_wzcn};

  always #2 clk = ~clk;                 // 4 ns period

  risc8_alu UUT (.*);
  alu_checker u_chk (.*);

  // random fields narrowed by phase
  task automatic random_op(input int ph, input int i);
    a_src     = 2'($urandom);
    b_src     = 2'($urandom);
    carry_src = 3'($urandom);
    alu_cmd   = 4'($urandom_range(11, 0));
    invert_b  = 1'($urandom);
    flag_op   = fl_codes[$urandom_range(5, 0)];
    queue_out = 8'($urandom);
    a_data    = 8'($urandom);
    b_data    = 8'($urandom);
    psw       = 8'($urandom);
    if (i < 16)                         // corner operand pairs first
    begin
      a_data    = corner[i % 4];
      queue_out = corner[(i + 1) % 4];  // differs from a_data so a_src shows
      b_data    = corner[i / 4];
    end
    case (ph)
      1:                                // add, adc, subtract
      begin
        alu_cmd = alu_add;
        b_src   = 2'b00;
        flag_op = fl_zcnv;
        if (carry_src == cry_saved || carry_src > cry_c)
          carry_src = cry_one;
      end
      2:                                // low byte, then high byte
      begin
        alu_cmd = alu_add;
        if (i % 2 == 0)
        begin
          b_src     = 2'b00;
          carry_src = invert_b ? cry_one : cry_zero;
          flag_op   = fl_zcnv;
        end
        else
        begin
          b_src     = b_src[1] ? bsrc_sign : 2'b00;   // sign extension or register
          carry_src = cry_saved;
          flag_op   = fl_wzcn;
        end
      end
      3: alu_cmd = 4'($urandom_range(11, 1));        // logic unit only
      default: ;                                     // everything mixed
    endcase
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial
  begin
    void'($urandom(52620));
    rst_n     = 1'b0;
    a_src     = '0;
    b_src     = '0;
    carry_src = '0;
    alu_cmd   = '0;
    invert_b  = 1'b0;
    flag_op   = '0;
    queue_out = '0;
    a_data    = '0;
    b_data    = '0;
    psw       = '0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int ph = 1; ph <= n_phases; ph++)
    begin
      for (int i = 0; i < ops_per_phase; i++)
      begin
        @(posedge clk);
        #1;
        phase = ph;
        random_op(ph, i);
      end
    end
    repeat (2) @(negedge clk);          // last result compared
    #1;
    $display("checks %0d, value errors %0d, assertion failures %0d",
             check_count, err_count, UUT.u_res.u_asrt.fail_count);
    if (err_count == 0 && UUT.u_res.u_asrt.fail_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // ==================================================
  // timeout
  // ==================================================
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: run still going after %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

endmodule

// ==== list.f ====
rtl/alu_pkg.sv
rtl/alu_operand_if.sv
rtl/operand_select.sv
rtl/cla_adder.sv
rtl/logic_unit.sv
rtl/result_flags.sv
rtl/risc8_alu.sv
tb/alu_checker.sv
tb/alu_assert.sv
tb/tb_risc8_alu.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_risc8_alu -f list.f -o sim_alu
	./obj_dir/sim_alu +verilator+error+limit+1000 > sim.log 2>&1
	cat sim.log
	! grep -q "Some tests failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
